//--- dv/async_sram_model.sv
module async_sram_model #(
	parameter int BANK_ID = 0
) (
	input  sram_pkg::sram_pins_t           pins,
	output logic [ahb_pkg::AHB_DATA_W-1:0] dq
);
	import ahb_pkg::*;
	import sram_pkg::*;

	logic [AHB_DATA_W-1:0] mem [BANK_DEPTH];
	logic [AHB_DATA_W-1:0] lane_mask;
	logic                  we_n;

	// Power-up contents built from bank and word address
	initial begin
		for (int a = 0; a < BANK_DEPTH; a++)
			mem[a] = {8'(BANK_ID), 8'(a), ~8'(a), 8'h5A};
	end

	always_comb begin
		for (int l = 0; l < AHB_STRB_W; l++)
			lane_mask[8*l +: 8] = {8{!pins.byte_n[l]}};
	end

	assign we_n = pins.we_n;

	// Write lanes latch as the strobe falls
	always @(negedge we_n) begin
		if (!pins.ce_n && pins.dq_oe)
			mem[pins.addr] = (mem[pins.addr] & ~lane_mask) | (pins.dq_out & lane_mask);
	end

	// Chip drives the bus only for a read with the write strobe high
	assign dq = (!pins.ce_n && !pins.oe_n && pins.we_n) ? (mem[pins.addr] & lane_mask) : '0;

endmodule

//--- dv/sram_test_input.txt
// op (0 idle, 1 write, 2 read), gap (1 allows random idle cycles first), size (0 byte, 1 half, 2 word)
// addr, write data, expected read data, err (1 expects the ERROR response)
1 1 2 00000010 11111111 00000000 0
1 1 2 00000410 22222222 00000000 0
1 1 2 00000810 33333333 00000000 0
1 1 2 00000C14 44444444 00000000 0
2 1 2 00000010 00000000 11111111 0
2 1 2 00000410 00000000 22222222 0
2 1 2 00000810 00000000 33333333 0
2 1 2 00000C14 00000000 44444444 0
1 1 2 00000020 A0A1A2A3 00000000 0
1 1 0 00000021 0000BB00 00000000 0
2 1 2 00000020 00000000 A0A1BBA3 0
1 1 2 00000420 01234567 00000000 0
1 1 1 00000422 CCDD0000 00000000 0
2 1 2 00000420 00000000 CCDD4567 0
1 1 2 00000820 89ABCDEF 00000000 0
1 1 0 00000823 5A000000 00000000 0
1 0 0 00000820 0000007E 00000000 0
2 0 2 00000820 00000000 5AABCD7E 0
0 0 2 00000000 00000000 00000000 0
1 0 2 00000C40 DEADBEEF 00000000 0
2 0 2 00000C40 00000000 DEADBEEF 0
1 0 2 00000044 CAFEF00D 00000000 0
1 0 2 00000444 0BADC0DE 00000000 0
2 0 2 00000044 00000000 CAFEF00D 0
2 0 2 00000444 00000000 0BADC0DE 0
1 1 2 00001010 FFFFFFFF 00000000 1
2 0 2 80000000 00000000 00000000 1
2 0 2 00000010 00000000 11111111 0
2 1 2 00000C40 00000000 DEADBEEF 0

//--- dv/tb_sram_subsystem.sv
module tb_sram_subsystem;
	import ahb_pkg::*;
	import sram_pkg::*;

	localparam int REC_WORDS      = 7;
	localparam int MAX_RECS       = 64;
	localparam int CYCLES_PER_REC = 40;
	localparam logic [31:0] OP_IDLE  = 32'd0;
	localparam logic [31:0] OP_WRITE = 32'd1;

	logic                  clk;
	logic                  rst_n;
	logic                  hsel;
	logic [AHB_ADDR_W-1:0] haddr;
	logic                  hwrite;
	logic [1:0]            htrans;
	logic [2:0]            hsize;
	logic [2:0]            hburst;
	logic [3:0]            hprot;
	logic                  hmastlock;
	logic [AHB_DATA_W-1:0] hwdata;
	logic                  hready_in;
	logic                  hready;
	logic                  hresp;
	logic [AHB_DATA_W-1:0] hrdata;
	sram_pins_t            sram_pins [NUM_BANKS];
	logic [AHB_DATA_W-1:0] sram_dq_in [NUM_BANKS];

	// Seven words per transfer, see the data file
	logic [31:0] stim [MAX_RECS*REC_WORDS];

	// Transfer now in its data phase
	logic        dp_valid;
	logic        dp_write;
	logic        dp_err;
	logic [31:0] dp_addr;
	logic [31:0] dp_wdata;
	logic [31:0] dp_exp;
	int          dp_test;
	int          err_cycle;

	int   errors = 0;
	int   tests_run = 0;
	int   tests_failed = 0;
	logic test_bad = 1'b0;
	int   cycles = 0;
	int   cycle_limit = 0;

	sram_subsystem_top DUT (.*);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_chip
		async_sram_model #(.BANK_ID(b)) u_chip (.pins(sram_pins[b]), .dq(sram_dq_in[b]));
	end

	// Single slave on the bus, so HREADY loops straight back
	assign hready_in = hready;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run went past %0d clock cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_rdata(input logic [AHB_DATA_W-1:0] got, input logic [AHB_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t hrdata: got %h, expected %h", $time, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_resp(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	// Every chip deselected with its strobes high
	task automatic check_chips_idle();
		for (int b = 0; b < NUM_BANKS; b++) begin
			check_resp($sformatf("sram_pins[%0d].ce_n", b), sram_pins[b].ce_n, 1'b1);
			check_resp($sformatf("sram_pins[%0d].we_n", b), sram_pins[b].we_n, 1'b1);
			check_resp($sformatf("sram_pins[%0d].oe_n", b), sram_pins[b].oe_n, 1'b1);
			check_resp($sformatf("sram_pins[%0d].dq_oe", b), sram_pins[b].dq_oe, 1'b0);
		end
	endtask

	task automatic finish_test(input int num, input string what);
		tests_run++;
		if (test_bad)
			tests_failed++;
		$display("test %0d %s: %s", num, what, test_bad ? "FAILED" : "ok");
		test_bad = 1'b0;
	endtask

	task automatic close_data_phase();
		check_resp("hready", hready, !(dp_err && err_cycle == 0));
		check_resp("hresp", hresp, dp_err);
		if (dp_err)
			check_chips_idle();
		else if (!dp_write)
			check_rdata(hrdata, dp_exp);
	endtask

	// One clock of the pipelined master, entered just after a rising edge
	task automatic bus_cycle(input logic [31:0] op, input logic [31:0] size,
			input logic [31:0] addr, input logic [31:0] wdata, input logic [31:0] exp_data,
			input logic [31:0] err, input int test);
		logic hold;
		hold   = dp_valid && dp_err && err_cycle == 0;
		hsel   = (op != OP_IDLE);
		htrans = (op != OP_IDLE) ? NONSEQ : IDLE;
		haddr  = addr;
		hwrite = (op == OP_WRITE);
		hsize  = size[2:0];
		hwdata = (dp_valid && dp_write) ? dp_wdata : '0;
		@(negedge clk);
		if (dp_valid)
			close_data_phase();
		@(posedge clk);
		#1;
		if (hold) begin
			err_cycle = 1;
		end else begin
			if (dp_valid)
				finish_test(dp_test, $sformatf("%s %h%s", dp_write ? "write" : "read",
					dp_addr, dp_err ? " error" : ""));
			dp_valid  = (op != OP_IDLE);
			dp_write  = (op == OP_WRITE);
			dp_err    = (err != 0);
			dp_addr   = addr;
			dp_wdata  = wdata;
			dp_exp    = exp_data;
			dp_test   = test;
			err_cycle = 0;
		end
	endtask

	task automatic idle_cycle();
		bus_cycle(OP_IDLE, 32'd2, 32'd0, 32'd0, 32'd0, 32'd0, 0);
	endtask

	initial begin
		int n_recs;
		int base;
		int gap;
		void'($urandom(52629));
		rst_n = 1'b0;
		hsel = 1'b0;
		haddr = '0;
		hwrite = 1'b0;
		htrans = IDLE;
		hsize = WORD;
		hburst = '0;
		hprot = '0;
		hmastlock = 1'b0;
		hwdata = '0;
		dp_valid = 1'b0;
		dp_err = 1'b0;
		err_cycle = 0;
		for (int i = 0; i < MAX_RECS*REC_WORDS; i++)
			stim[i] = '1;
		$readmemh("dv/sram_test_input.txt", stim);
		n_recs = 0;
		while (n_recs < MAX_RECS && stim[n_recs*REC_WORDS] != '1)
			n_recs++;
		if (n_recs == 0) begin
			$display("No transfers could be read from dv/sram_test_input.txt");
			errors++;
		end
		cycle_limit = CYCLES_PER_REC * (n_recs + 1);
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_chips_idle();
		check_resp("hready", hready, 1'b1);
		check_resp("hresp", hresp, 1'b0);
		finish_test(0, "reset state");
		@(posedge clk);
		#1;
		for (int r = 0; r < n_recs; r++) begin
			base = r * REC_WORDS;
			// The address phase under the first error cycle must be IDLE
			if (dp_valid && dp_err)
				idle_cycle();
			if (stim[base+1] != 0) begin
				gap = $urandom_range(2, 0);
				repeat (gap) idle_cycle();
			end
			bus_cycle(stim[base], stim[base+2], stim[base+3], stim[base+4], stim[base+5],
				stim[base+6], r + 1);
		end
		while (dp_valid)
			idle_cycle();
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SRAM subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_sram_subsystem
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -Mdir "$OBJ" -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- source/ahb_async_sram.sv
module ahb_async_sram (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           sel,
	input  logic                           hready_in,
	input  ahb_pkg::ahb_req_t              req,
	input  logic [ahb_pkg::AHB_DATA_W-1:0] hwdata,
	output sram_pkg::sram_pins_t           pins,
	input  logic [ahb_pkg::AHB_DATA_W-1:0] dq_in,
	output logic [ahb_pkg::AHB_DATA_W-1:0] rdata
);
	import ahb_pkg::*;
	import sram_pkg::*;

	logic [AHB_STRB_W-1:0]     size_mask;
	logic [AHB_STRB_W-1:0]     byte_mask;
	logic [AHB_BYTE_OFS_W-1:0] byte_ofs;

	logic [SRAM_ADDR_W-1:0] addr_q;
	logic                   ce_n_q;
	logic                   we_n_q;
	logic                   oe_n_q;
	logic [AHB_STRB_W-1:0]  byte_n_q;

	// Lanes touched by this transfer
	assign byte_ofs = req.haddr[AHB_BYTE_OFS_W-1:0];

	always_comb begin
		case (req.hsize)
			BYTE:    size_mask = 4'b0001;
			HALF:    size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	assign byte_mask = size_mask << byte_ofs;

	// Strobes latch at the end of the address phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q   <= '0;
			ce_n_q   <= 1'b1;
			we_n_q   <= 1'b1;
			oe_n_q   <= 1'b1;
			byte_n_q <= '1;
		end else if (hready_in) begin
			if (sel) begin
				addr_q   <= req.haddr[AHB_BYTE_OFS_W +: SRAM_ADDR_W];
				ce_n_q   <= 1'b0;
				we_n_q   <= !req.hwrite;
				oe_n_q   <= req.hwrite;
				byte_n_q <= ~byte_mask;
			end else begin
				ce_n_q   <= 1'b1;
				we_n_q   <= 1'b1;
				oe_n_q   <= 1'b1;
				byte_n_q <= '1;
			end
		end
	end

	// we_n only goes low while clk is low, in the back half of the data phase
	always_comb begin
		pins.addr   = addr_q;
		pins.ce_n   = ce_n_q;
		pins.we_n   = we_n_q | clk;
		pins.oe_n   = oe_n_q;
		pins.byte_n = byte_n_q;
		pins.dq_out = hwdata;
		pins.dq_oe  = !we_n_q;
	end

	// Idle banks return zero
	assign rdata = dq_in & {AHB_DATA_W{!oe_n_q}};

endmodule

//--- source/ahb_bank_decoder.sv
module ahb_bank_decoder (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            hsel,
	input  logic                            hready_in,
	input  ahb_pkg::ahb_req_t               req_in,
	output logic [sram_pkg::NUM_BANKS-1:0]  bank_valid,
	output ahb_pkg::ahb_req_t               req,
	output logic                            err_busy,
	output logic                            err_last
);
	import ahb_pkg::*;
	import sram_pkg::*;

	typedef enum logic [1:0] {
		ERR_NONE,
		ERR_FIRST,
		ERR_SECOND
	} err_state_e;

	err_state_e err_state;
	logic       accept;
	logic       mapped;
	logic       err_start;

	// Transfers are ignored while the first error cycle is running
	assign accept = hsel && hready_in && !err_busy &&
		(req_in.htrans == NONSEQ || req_in.htrans == SEQ);
	assign mapped    = (req_in.haddr < MAPPED_BYTES);
	assign err_start = accept && !mapped;

	always_comb begin
		bank_valid = '0;
		if (accept && mapped)
			bank_valid[req_in.haddr[BANK_LSB +: BANK_SEL_W]] = 1'b1;
	end

	// All controllers see the same address phase
	assign req = req_in;

	// Two-cycle ERROR response
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_state <= ERR_NONE;
		end else begin
			case (err_state)
				ERR_NONE:   if (err_start) err_state <= ERR_FIRST;
				// This slave holds hready low here, so always advance
				ERR_FIRST:  err_state <= ERR_SECOND;
				ERR_SECOND: if (hready_in) err_state <= err_start ? ERR_FIRST : ERR_NONE;
				default:    err_state <= ERR_NONE;
			endcase
		end
	end

	assign err_busy = (err_state == ERR_FIRST);
	assign err_last = (err_state == ERR_SECOND);

endmodule

//--- source/ahb_pkg.sv
package ahb_pkg;

	// Bus geometry
	localparam int AHB_ADDR_W = 32;
	localparam int AHB_DATA_W = 32;
	localparam int AHB_STRB_W = AHB_DATA_W / 8;

	// Byte offset bits inside one data word
	localparam int AHB_BYTE_OFS_W = $clog2(AHB_STRB_W);

	// HTRANS encodings
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} ahb_trans_e;

	// HSIZE encodings, only the sizes up to the bus width
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} ahb_size_e;

	// Address phase of one transfer
	typedef struct packed {
		logic [AHB_ADDR_W-1:0] haddr;
		logic                  hwrite;
		ahb_trans_e            htrans;
		ahb_size_e             hsize;
	} ahb_req_t;

endpackage

//--- source/ahb_read_mux.sv
module ahb_read_mux (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           hready_in,
	input  logic [sram_pkg::NUM_BANKS-1:0] bank_valid,
	input  logic [ahb_pkg::AHB_DATA_W-1:0] rdata [sram_pkg::NUM_BANKS],
	input  logic                           err_busy,
	input  logic                           err_last,
	output logic [ahb_pkg::AHB_DATA_W-1:0] hrdata,
	output logic                           hready,
	output logic                           hresp
);
	import ahb_pkg::*;
	import sram_pkg::*;

	logic [BANK_SEL_W-1:0] bank_idx;
	logic [BANK_SEL_W-1:0] bank_q;
	logic [AHB_DATA_W-1:0] sel_data;

	// One-hot select to index
	always_comb begin
		bank_idx = '0;
		for (int i = 0; i < NUM_BANKS; i++)
			if (bank_valid[i])
				bank_idx = BANK_SEL_W'(i);
	end

	// Bank of the transfer now in its data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bank_q <= '0;
		else if (hready_in && |bank_valid)
			bank_q <= bank_idx;
	end

	assign sel_data = rdata[bank_q];
	assign hrdata   = sel_data;

	assign hready = !err_busy;
	assign hresp  = err_busy || err_last;

endmodule

//--- source/sram_pkg.sv
package sram_pkg;

	// Bank geometry
	localparam int NUM_BANKS   = 4;
	localparam int BANK_DEPTH  = 256;
	localparam int SRAM_ADDR_W = $clog2(BANK_DEPTH);
	localparam int BANK_SEL_W  = $clog2(NUM_BANKS);

	// Bank bits sit right above the chip word address
	localparam int BANK_LSB = SRAM_ADDR_W + ahb_pkg::AHB_BYTE_OFS_W;

	// Size of the populated region in bytes
	localparam int MAPPED_BYTES = NUM_BANKS * BANK_DEPTH * ahb_pkg::AHB_STRB_W;

	// Pins of one async SRAM chip, dq split into separate directions
	typedef struct packed {
		logic [SRAM_ADDR_W-1:0]          addr;
		logic                            ce_n;
		logic                            we_n;
		logic                            oe_n;
		logic [ahb_pkg::AHB_STRB_W-1:0]  byte_n;
		logic [ahb_pkg::AHB_DATA_W-1:0]  dq_out;
		logic                            dq_oe;
	} sram_pins_t;

endpackage

//--- source/sram_subsystem_top.sv
module sram_subsystem_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           hsel,
	input  logic [ahb_pkg::AHB_ADDR_W-1:0] haddr,
	input  logic                           hwrite,
	input  logic [1:0]                     htrans,
	input  logic [2:0]                     hsize,
	input  logic [2:0]                     hburst,
	input  logic [3:0]                     hprot,
	input  logic                           hmastlock,
	input  logic [ahb_pkg::AHB_DATA_W-1:0] hwdata,
	input  logic                           hready_in,
	output logic                           hready,
	output logic                           hresp,
	output logic [ahb_pkg::AHB_DATA_W-1:0] hrdata,
	output sram_pkg::sram_pins_t           sram_pins [sram_pkg::NUM_BANKS],
	input  logic [ahb_pkg::AHB_DATA_W-1:0] sram_dq_in [sram_pkg::NUM_BANKS]
);
	import ahb_pkg::*;
	import sram_pkg::*;

	ahb_req_t              req_in;
	ahb_req_t              req;
	logic [NUM_BANKS-1:0]  bank_valid;
	logic [AHB_DATA_W-1:0] bank_rdata [NUM_BANKS];
	logic                  err_busy;
	logic                  err_last;

	// Burst, protection and lock are not used by this slave
	always_comb begin
		req_in.haddr  = haddr;
		req_in.hwrite = hwrite;
		req_in.htrans = ahb_trans_e'(htrans);
		req_in.hsize  = ahb_size_e'(hsize);
	end

	ahb_bank_decoder u_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.hsel       (hsel),
		.hready_in  (hready_in),
		.req_in     (req_in),
		.bank_valid (bank_valid),
		.req        (req),
		.err_busy   (err_busy),
		.err_last   (err_last)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		ahb_async_sram u_ctrl (
			.clk       (clk),
			.rst_n     (rst_n),
			.sel       (bank_valid[i]),
			.hready_in (hready_in),
			.req       (req),
			.hwdata    (hwdata),
			.pins      (sram_pins[i]),
			.dq_in     (sram_dq_in[i]),
			.rdata     (bank_rdata[i])
		);
	end

	ahb_read_mux u_mux (
		.clk        (clk),
		.rst_n      (rst_n),
		.hready_in  (hready_in),
		.bank_valid (bank_valid),
		.rdata      (bank_rdata),
		.err_busy   (err_busy),
		.err_last   (err_last),
		.hrdata     (hrdata),
		.hready     (hready),
		.hresp      (hresp)
	);

endmodule

//--- vlog.f
source/ahb_pkg.sv
source/sram_pkg.sv
source/ahb_bank_decoder.sv
source/ahb_async_sram.sv
source/ahb_read_mux.sv
source/sram_subsystem_top.sv
dv/async_sram_model.sv
dv/tb_sram_subsystem.sv
